// ==== compile.f ====
design/exec_pkg.sv
design/wb_exec_frontend.sv
design/rv32_op_decode.sv
design/rv32im_alu.sv
design/exec_status_regs.sv
design/exec_unit_top.sv
verif/exec_unit_assertions.sv
verif/tb_exec_unit.sv

// ==== Makefile ====
TOP  := tb_exec_unit
SRCS := $(shell cat compile.f)

.PHONY: run clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

obj_dir/V$(TOP): compile.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir

clean:
	rm -rf obj_dir

// ==== verif/tb_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit
  import exec_pkg::*;
();

  localparam int XLEN       = 32;
  localparam int CLK_PERIOD = 8;
  localparam int ACK_LIMIT  = 16;
  // run_insn calls per test
  // each run is five bus ops of three clocks
  localparam int RUNS    = 4 * 10 + 18 + 4 + 4 + 40;
  localparam int BUS_OPS = 8 + 5 * RUNS;

  // corner operand pairs with shift amounts 0, 31, 32 and 31
  localparam logic [31:0] CORNER_A [4] = '{32'hffff_ffff, 32'h8000_0000,
                                           32'h8000_0000, 32'h0000_0000};
  localparam logic [31:0] CORNER_B [4] = '{32'h0000_0000, 32'h0000_001f,
                                           32'h0000_0020, 32'hffff_ffff};
  // sign-bit only, equal, reversed order
  localparam logic [31:0] FLAG_A [4] = '{32'h8000_0001, 32'h0000_1234,
                                         32'h0000_0001, 32'hffff_ffff};
  localparam logic [31:0] FLAG_B [4] = '{32'h0000_0001, 32'h0000_1234,
                                         32'h8000_0001, 32'h0000_0000};
  // addi slti sltiu xori ori andi
  localparam logic [2:0] IMM_F3 [6] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};

  logic        clk = 1'b0;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [4:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  // reference model state
  logic [31:0] exp_result;
  logic        exp_eq;
  logic        exp_lt;
  logic        exp_lts;
  logic        exp_ill;
  logic        exp_done;
  integer      seed = 92;

  always #(CLK_PERIOD / 2) clk = ~clk;

  exec_unit_top #(
    .XLEN (XLEN)
  ) u_dut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_sel_i (wb_sel),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  bind exec_unit_top exec_unit_assertions u_assertions (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_i (wb_ack_o),
    .start_i  (start),
    .done_i   (u_status.done)
  );

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      fail_stop($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // rv32i funct3 meaning for OP and OP-IMM
  function automatic alu_op_e funct3_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // expected state after one insn write
  function automatic void predict(input logic [31:0] op1, input logic [31:0] op2,
                                  input logic [31:0] insn);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] b;
    logic        legal;
    alu_op_e     op;
    f7    = insn[31:25];
    f3    = insn[14:12];
    b     = op2;
    legal = 1'b0;
    op    = funct3_op(f3);
    if (insn[6:0] == OPC_OP) begin
      // base encodings plus sub/sra via bit 30 and no mul/div
      legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      if (f7 == 7'h20) begin
        op = (f3 == 3'b000) ? ALU_SUB : ALU_SRA;
      end
    end else if (insn[6:0] == OPC_OP_IMM) begin
      b = {{20{insn[31]}}, insn[31:20]};
      if (f3 == 3'b001) begin
        legal = (f7 == 7'h00);
      end else if (f3 == 3'b101) begin
        legal = (f7 == 7'h00) || (f7 == 7'h20);
        op    = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
      end else begin
        legal = 1'b1;
      end
    end
    exp_done = 1'b1;
    exp_ill  = ~legal;
    // illegal leaves result and flags alone
    if (legal) begin
      exp_eq  = (op1 == b);
      exp_lt  = (op1 < b);
      exp_lts = ($signed(op1) < $signed(b));
      case (op)
        ALU_ADD:  exp_result = op1 + b;
        ALU_SUB:  exp_result = op1 - b;
        ALU_SLL:  exp_result = op1 << b[4:0];
        ALU_SLT:  exp_result = {31'd0, exp_lts};
        ALU_SLTU: exp_result = {31'd0, exp_lt};
        ALU_XOR:  exp_result = op1 ^ b;
        ALU_SRL:  exp_result = op1 >> b[4:0];
        ALU_SRA:  exp_result = $signed(op1) >>> b[4:0];
        ALU_OR:   exp_result = op1 | b;
        default:  exp_result = op1 & b;
      endcase
    end
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3);
    return {imm, 5'd1, f3, 5'd3, OPC_OP_IMM};
  endfunction

  // ack sampled on the falling edge away from register updates
  task automatic wait_ack();
    int n;
    n = 0;
    @(negedge clk);
    while (!wb_ack && n < ACK_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (wb_ack) else begin
      fail_stop("no ack from the DUT within the bus timeout");
    end
  endtask

  task automatic wb_write(input logic [2:0] idx, input logic [31:0] data);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= {idx, 2'b00};
    wb_dat_w <= data;
    wait_ack();
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [2:0] idx, output logic [31:0] data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= {idx, 2'b00};
    wait_ack();
    data = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  // operands, insn, then result and status readback
  task automatic run_insn(input logic [31:0] op1, input logic [31:0] op2,
                          input logic [31:0] insn);
    logic [31:0] got;
    logic [31:0] exp_status;
    wb_write(ADDR_OPERAND1, op1);
    wb_write(ADDR_OPERAND2, op2);
    wb_write(ADDR_INSN, insn);
    predict(op1, op2, insn);
    exp_status                     = '0;
    exp_status[STATUS_EQUAL]       = exp_eq;
    exp_status[STATUS_LESS]        = exp_lt;
    exp_status[STATUS_LESS_SIGNED] = exp_lts;
    exp_status[STATUS_ILLEGAL]     = exp_ill;
    exp_status[STATUS_DONE]        = exp_done;
    wb_read(ADDR_RESULT, got);
    check("RESULT", got, exp_result);
    wb_read(ADDR_STATUS, got);
    check("STATUS", got, exp_status);
  endtask

  task automatic reset_and_readback();
    logic [31:0] got;
    wb_read(ADDR_RESULT, got);
    check("RESULT", got, 32'h0);
    wb_read(ADDR_STATUS, got);
    check("STATUS", got, 32'h0);
    wb_write(ADDR_OPERAND1, 32'hcafe_0123);
    wb_write(ADDR_OPERAND2, 32'h5a5a_a5a5);
    wb_write(ADDR_INSN, r_type(7'h00, 3'b110));
    // keep the model in step with this execution
    predict(32'hcafe_0123, 32'h5a5a_a5a5, r_type(7'h00, 3'b110));
    wb_read(ADDR_OPERAND1, got);
    check("OPERAND1", got, 32'hcafe_0123);
    wb_read(ADDR_OPERAND2, got);
    check("OPERAND2", got, 32'h5a5a_a5a5);
    wb_read(ADDR_INSN, got);
    check("INSN", got, r_type(7'h00, 3'b110));
  endtask

  task automatic reg_reg_ops();
    for (int p = 0; p < 4; p++) begin
      for (int f = 0; f < 8; f++) begin
        run_insn(CORNER_A[p], CORNER_B[p], r_type(7'h00, 3'(f)));
      end
      run_insn(CORNER_A[p], CORNER_B[p], r_type(7'h20, 3'b000));
      run_insn(CORNER_A[p], CORNER_B[p], r_type(7'h20, 3'b101));
    end
  endtask

  task automatic imm_ops();
    logic [31:0] op1;
    logic [31:0] junk;
    logic [11:0] imm;
    logic [4:0]  sh;
    for (int v = 0; v < 2; v++) begin
      op1 = (v == 0) ? 32'h8000_0f10 : 32'h0000_0070;
      imm = (v == 0) ? 12'hff8 : 12'h07f;
      sh  = (v == 0) ? 5'd3 : 5'd31;
      // operand2 register content must not matter
      junk = $random(seed);
      for (int k = 0; k < 6; k++) begin
        run_insn(op1, junk, i_type(imm, IMM_F3[k]));
      end
      run_insn(op1, junk, i_type({7'h00, sh}, 3'b001));
      run_insn(op1, junk, i_type({7'h00, sh}, 3'b101));
      run_insn(op1, junk, i_type({7'h20, sh}, 3'b101));
    end
  endtask

  task automatic compare_flags();
    for (int p = 0; p < 4; p++) begin
      run_insn(FLAG_A[p], FLAG_B[p], r_type(7'h00, p[0] ? 3'b011 : 3'b010));
    end
  endtask

  task automatic illegal_insns();
    run_insn(32'd5, 32'd6, r_type(7'h00, 3'b000));
    // mul, lw, sub with a bad funct7
    run_insn(32'd9, 32'd3, r_type(7'h01, 3'b000));
    run_insn(32'd9, 32'd3, {12'h004, 5'd1, 3'b010, 5'd3, 7'b0000011});
    run_insn(32'd9, 32'd3, r_type(7'h10, 3'b000));
  endtask

  task automatic random_mix();
    logic [31:0] insn;
    logic [31:0] sel;
    logic [31:0] op1;
    logic [31:0] op2;
    for (int i = 0; i < 40; i++) begin
      insn = $random(seed);
      sel  = $random(seed);
      op1  = $random(seed);
      op2  = $random(seed);
      case (sel[1:0])
        2'd0:    insn[6:0] = OPC_OP;
        2'd1:    insn[6:0] = OPC_OP_IMM;
        2'd2:    insn[6:0] = OPC_OP;
        default: insn[6:0] = 7'b0000011;
      endcase
      // bias funct7 towards base, alternate and M encodings
      case (sel[3:2])
        2'd0:    insn[31:25] = 7'h00;
        2'd1:    insn[31:25] = 7'h20;
        2'd2:    insn[31:25] = 7'h01;
        default: insn[31:25] = insn[31:25];
      endcase
      run_insn(op1, op2, insn);
    end
  endtask

  initial begin
    #(CLK_PERIOD * (BUS_OPS * 3 + 20) * 2);
    fail_stop("watchdog timeout, the tests did not finish in time");
  end

  initial begin
    rst_n      <= 1'b0;
    wb_cyc     <= 1'b0;
    wb_stb     <= 1'b0;
    wb_we      <= 1'b0;
    wb_adr     <= 5'd0;
    wb_dat_w   <= 32'd0;
    wb_sel     <= 4'hf;
    exp_result = 32'd0;
    exp_eq     = 1'b0;
    exp_lt     = 1'b0;
    exp_lts    = 1'b0;
    exp_ill    = 1'b0;
    exp_done   = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    reset_and_readback();
    reg_reg_ops();
    imm_ops();
    compare_flags();
    illegal_insns();
    random_mix();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/exec_unit_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_assertions (
  input wire logic clk_i,
  input wire logic rst_n_i,
  input wire logic wb_cyc_i,
  input wire logic wb_stb_i,
  input wire logic wb_ack_i,
  input wire logic start_i,
  input wire logic done_i
);

  // ack answers a request seen on the edge before
  ack_after_request: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |-> $past(wb_cyc_i && wb_stb_i)
  ) else $error("ack without a preceding cyc/stb request");

  // classic single-pulse ack
  ack_single_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i
  ) else $error("ack held for more than one cycle");

  // reset clears the bus handshake
  ack_low_after_reset: assert property (
    @(posedge clk_i)
    !rst_n_i |=> !wb_ack_i
  ) else $error("ack high on the cycle after reset");

  // done drops for the start cycle and returns one clock later
  done_after_start: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    start_i |=> (done_i && !$past(done_i))
  ) else $error("done not cleared in the start cycle or not set one cycle later");

endmodule

`default_nettype wire

// ==== design/exec_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit_top
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  // wishbone classic slave
  input  wire logic              wb_cyc_i,
  input  wire logic              wb_stb_i,
  input  wire logic              wb_we_i,
  input  wire logic [4:0]        wb_adr_i,
  input  wire logic [XLEN-1:0]   wb_dat_i,
  // byte lanes, full-word access only
  input  wire logic [XLEN/8-1:0] wb_sel_i,
  output logic      [XLEN-1:0]   wb_dat_o,
  output logic                   wb_ack_o
);

  logic [XLEN-1:0] operand1;
  logic [XLEN-1:0] operand2;
  logic [31:0]     insn;
  logic            start;
  alu_op_e         alu_op;
  logic [XLEN-1:0] alu_operand2;
  logic            illegal;
  logic            data_ready;
  logic [XLEN-1:0] result;
  logic            equal;
  logic            less;
  logic            less_signed;
  logic [XLEN-1:0] rd_data;

  // input side, bus slave and operand regs
  wb_exec_frontend #(
    .XLEN (XLEN)
  ) u_frontend (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .rd_data_i  (rd_data),
    .operand1_o (operand1),
    .operand2_o (operand2),
    .insn_o     (insn),
    .start_o    (start)
  );

  rv32_op_decode #(
    .XLEN (XLEN)
  ) u_decode (
    .insn_i         (insn),
    .operand2_i     (operand2),
    .alu_op_o       (alu_op),
    .alu_operand2_o (alu_operand2),
    .illegal_o      (illegal)
  );

  // illegal insns never reach the alu registers
  assign data_ready = start & ~illegal;

  rv32im_alu #(
    .XLEN (XLEN)
  ) u_alu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .data_ready_i  (data_ready),
    .operation_i   (alu_op),
    .operand1_i    (operand1),
    .operand2_i    (alu_operand2),
    .result_o      (result),
    .equal_o       (equal),
    .less_o        (less),
    .less_signed_o (less_signed)
  );

  // output side, status bits and read mux
  exec_status_regs #(
    .XLEN (XLEN)
  ) u_status (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (start),
    .illegal_i     (illegal),
    .adr_i         (wb_adr_i),
    .operand1_i    (operand1),
    .operand2_i    (operand2),
    .insn_i        (insn),
    .result_i      (result),
    .equal_i       (equal),
    .less_i        (less),
    .less_signed_i (less_signed),
    .rd_data_o     (rd_data)
  );

endmodule

`default_nettype wire

// ==== design/exec_status_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_status_regs
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  input  wire logic            start_i,
  input  wire logic            illegal_i,
  // bus address for the read mux
  input  wire logic [4:0]      adr_i,
  // readable registers
  input  wire logic [XLEN-1:0] operand1_i,
  input  wire logic [XLEN-1:0] operand2_i,
  input  wire logic [31:0]     insn_i,
  input  wire logic [XLEN-1:0] result_i,
  input  wire logic            equal_i,
  input  wire logic            less_i,
  input  wire logic            less_signed_i,
  output logic      [XLEN-1:0] rd_data_o
);

  logic            done_q;
  logic            done;
  logic            illegal_q;
  logic [XLEN-1:0] status_word;
  logic [XLEN-1:0] insn_word;
  logic [2:0]      word_idx;

  // done sets on the edge that ends the start cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else if (start_i) begin
      done_q <= 1'b1;
    end
  end

  // new execution in flight, hide the old done
  assign done = done_q & ~start_i;

  // illegal flag of the last started insn
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      illegal_q <= 1'b0;
    end else if (start_i) begin
      illegal_q <= illegal_i;
    end
  end

  // status word assembly
  always_comb begin
    status_word                     = '0;
    status_word[STATUS_EQUAL]       = equal_i;
    status_word[STATUS_LESS]        = less_i;
    status_word[STATUS_LESS_SIGNED] = less_signed_i;
    status_word[STATUS_ILLEGAL]     = illegal_q;
    status_word[STATUS_DONE]        = done;
  end

  // insn is always 32 bits wide
  assign insn_word = XLEN'(insn_i);

  assign word_idx = adr_i[4:2];

  // read mux, unmapped words read zero
  always_comb begin
    case (word_idx)
      ADDR_OPERAND1: rd_data_o = operand1_i;
      ADDR_OPERAND2: rd_data_o = operand2_i;
      ADDR_INSN:     rd_data_o = insn_word;
      ADDR_RESULT:   rd_data_o = result_i;
      ADDR_STATUS:   rd_data_o = status_word;
      default:       rd_data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/rv32im_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32im_alu
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  input  wire logic            data_ready_i,
  input  alu_op_e              operation_i,
  input  wire logic [XLEN-1:0] operand1_i,
  input  wire logic [XLEN-1:0] operand2_i,
  output logic      [XLEN-1:0] result_o,
  output logic                 equal_o,
  output logic                 less_o,
  output logic                 less_signed_o
);

  localparam int SHW = $clog2(XLEN);

  logic                   equal;
  logic                   less;
  logic                   less_signed;
  logic        [SHW-1:0]  shamt;
  logic signed [XLEN-1:0] operand1_signed;
  logic signed [XLEN-1:0] operand2_signed;
  logic        [XLEN-1:0] sll;
  logic        [XLEN-1:0] srl;
  logic        [XLEN-1:0] sra;

  // compares against operand2 as given (reg or imm)
  assign operand1_signed = operand1_i;
  assign operand2_signed = operand2_i;
  assign equal           = (operand1_i == operand2_i);
  assign less            = (operand1_i < operand2_i);
  assign less_signed     = (operand1_signed < operand2_signed);

  // only the low log2(xlen) bits shift
  assign shamt = operand2_i[SHW-1:0];
  assign sll   = operand1_i << shamt;
  assign srl   = operand1_i >> shamt;
  assign sra   = operand1_signed >>> shamt;

  // result register, holds between operations
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_o <= '0;
    end else if (data_ready_i) begin
      case (operation_i)
        ALU_ADD:  result_o <= operand1_i + operand2_i;
        ALU_SUB:  result_o <= operand1_i - operand2_i;
        // slt is signed, sltu unsigned
        ALU_SLT:  result_o <= {{(XLEN-1){1'b0}}, less_signed};
        ALU_SLTU: result_o <= {{(XLEN-1){1'b0}}, less};
        ALU_AND:  result_o <= operand1_i & operand2_i;
        ALU_OR:   result_o <= operand1_i | operand2_i;
        ALU_XOR:  result_o <= operand1_i ^ operand2_i;
        ALU_SLL:  result_o <= sll;
        ALU_SRL:  result_o <= srl;
        ALU_SRA:  result_o <= sra;
        default:  result_o <= '0;
      endcase
    end
  end

  // compare flags, same update rule as the result
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      equal_o       <= 1'b0;
      less_o        <= 1'b0;
      less_signed_o <= 1'b0;
    end else if (data_ready_i) begin
      equal_o       <= equal;
      less_o        <= less;
      less_signed_o <= less_signed;
    end
  end

endmodule

`default_nettype wire

// ==== design/rv32_op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_op_decode
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire logic [31:0]     insn_i,
  input  wire logic [XLEN-1:0] operand2_i,
  output alu_op_e              alu_op_o,
  output logic      [XLEN-1:0] alu_operand2_o,
  output logic                 illegal_o
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;

  // instruction fields
  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  // i-type immediate, sign extended
  assign imm_i = {{(XLEN-12){insn_i[31]}}, insn_i[31:20]};

  always_comb begin
    // safe defaults, illegal unless matched below
    alu_op_o       = ALU_ADD;
    alu_operand2_o = operand2_i;
    illegal_o      = 1'b1;

    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          alu_op_o  = alu_op_e'({1'b0, funct3});
          illegal_o = 1'b0;
        end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          // sub and sra
          alu_op_o  = alu_op_e'({1'b1, funct3});
          illegal_o = 1'b0;
        end
        // 0000001 is mul/div, left illegal
      end

      OPC_OP_IMM: begin
        alu_operand2_o = imm_i;
        case (funct3)
          3'b001: begin
            // slli, upper bits must be zero
            if (funct7 == 7'b0000000) begin
              alu_op_o  = ALU_SLL;
              illegal_o = 1'b0;
            end
          end
          3'b101: begin
            // srli or srai
            if (funct7 == 7'b0000000) begin
              alu_op_o  = ALU_SRL;
              illegal_o = 1'b0;
            end else if (funct7 == 7'b0100000) begin
              alu_op_o  = ALU_SRA;
              illegal_o = 1'b0;
            end
          end
          default: begin
            // addi slti sltiu xori ori andi, bit 30 is part of the imm
            alu_op_o  = alu_op_e'({1'b0, funct3});
            illegal_o = 1'b0;
          end
        endcase
      end

      default: begin
        // loads, stores, branches etc. not handled here
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/wb_exec_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_exec_frontend
  import exec_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  // wishbone classic slave
  input  wire logic            wb_cyc_i,
  input  wire logic            wb_stb_i,
  input  wire logic            wb_we_i,
  input  wire logic [4:0]      wb_adr_i,
  input  wire logic [XLEN-1:0] wb_dat_i,
  output logic      [XLEN-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  // read data from the status block
  input  wire logic [XLEN-1:0] rd_data_i,
  // towards decoder and alu
  output logic      [XLEN-1:0] operand1_o,
  output logic      [XLEN-1:0] operand2_o,
  output logic      [31:0]     insn_o,
  output logic                 start_o
);

  logic       accept;
  logic       wr_accept;
  logic       rd_accept;
  logic [2:0] word_idx;

  // one request accepted per ack pulse
  assign accept    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_accept = accept & wb_we_i;
  assign rd_accept = accept & ~wb_we_i;

  // byte offset ignored, full words only
  assign word_idx = wb_adr_i[4:2];

  // single-cycle ack, never back to back
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= accept;
    end
  end

  // writable registers
  // writes to result/status just get acked
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      operand1_o <= '0;
      operand2_o <= '0;
      insn_o     <= '0;
    end else if (wr_accept) begin
      case (word_idx)
        ADDR_OPERAND1: operand1_o <= wb_dat_i;
        ADDR_OPERAND2: operand2_o <= wb_dat_i;
        ADDR_INSN:     insn_o     <= wb_dat_i[31:0];
        default: begin
          // read-only or unmapped, nothing to do
        end
      endcase
    end
  end

  // start rises together with the ack of an insn write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_o <= 1'b0;
    end else begin
      start_o <= wr_accept & (word_idx == ADDR_INSN);
    end
  end

  // capture read data for the ack cycle
  // rd_data_i already muxed by address
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      wb_dat_o <= rd_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  // alu operation, encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  // major opcodes handled by the unit
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011
  } rv_opcode_e;

  // register map, word index from adr[4:2]
  localparam logic [2:0] ADDR_OPERAND1 = 3'd0;
  localparam logic [2:0] ADDR_OPERAND2 = 3'd1;
  localparam logic [2:0] ADDR_INSN     = 3'd2;
  localparam logic [2:0] ADDR_RESULT   = 3'd3;
  localparam logic [2:0] ADDR_STATUS   = 3'd4;

  // status word bit positions
  localparam int STATUS_EQUAL       = 0;
  localparam int STATUS_LESS        = 1;
  localparam int STATUS_LESS_SIGNED = 2;
  localparam int STATUS_ILLEGAL     = 3;
  localparam int STATUS_DONE        = 4;

endpackage

`default_nettype wire
